// File: Bender.yml
package:
  name: mm_accel

sources:
  - src/mm_pkg.sv
  - src/buf_if.sv
  - src/mm_csr.sv
  - src/operand_buffer.sv
  - src/dma_engine.sv
  - src/mm_engine.sv
  - src/mm_top.sv
  - target: test
    files:
      - test/tb_axi_mem.sv
      - test/tb_mm_top.sv

// File: flist.f
src/mm_pkg.sv
src/buf_if.sv
src/mm_csr.sv
src/operand_buffer.sv
src/dma_engine.sv
src/mm_engine.sv
src/mm_top.sv
test/tb_axi_mem.sv
test/tb_mm_top.sv

// File: src/buf_if.sv
// ==========================================================
// operand buffer port bundle
// one write side from the DMA, one read side to the engine
// ==========================================================
`default_nettype none

interface buf_if;
    import mm_pkg::*;

    logic              we;
    logic [BUF_AW-1:0] waddr;
    line_t             wdata;
    logic [BUF_AW-1:0] raddr;
    // valid one cycle after raddr
    line_t             rdata;

    modport writer (output we, waddr, wdata);
    modport reader (output raddr, input rdata);
    modport mem    (input we, waddr, wdata, raddr, output rdata);

endinterface

`default_nettype wire

// File: src/dma_engine.sv
// ==========================================================
// DMA engine
// reads A and B over AXI into the operand buffers, starts
// the multiply and writes C back as one 16-beat burst
// ==========================================================
`default_nettype none

module dma_engine (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    output logic                  done_o,
    input  wire  [31:0]           mat_a_addr_i,
    input  wire  [31:0]           mat_b_addr_i,
    input  wire  [31:0]           mat_c_addr_i,
    output logic [3:0]            axi_arid_o,
    output logic [31:0]           axi_araddr_o,
    output logic [7:0]            axi_arlen_o,
    output logic [2:0]            axi_arsize_o,
    output logic [1:0]            axi_arburst_o,
    output logic                  axi_arvalid_o,
    input  wire                   axi_arready_i,
    input  wire  [3:0]            axi_rid_i,
    input  wire  [31:0]           axi_rdata_i,
    input  wire                   axi_rvalid_i,
    output logic                  axi_rready_o,
    output logic [31:0]           axi_awaddr_o,
    output logic [7:0]            axi_awlen_o,
    output logic [2:0]            axi_awsize_o,
    output logic [1:0]            axi_awburst_o,
    output logic                  axi_awvalid_o,
    input  wire                   axi_awready_i,
    output logic [31:0]           axi_wdata_o,
    output logic                  axi_wlast_o,
    output logic                  axi_wvalid_o,
    input  wire                   axi_wready_i,
    input  wire                   axi_bvalid_i,
    output logic                  axi_bready_o,
    buf_if.writer                 buf_a,
    buf_if.writer                 buf_b,
    output logic                  mm_start_o,
    input  wire                   mm_done_i,
    input  var mm_pkg::acc_array_t accum_i
);
    import mm_pkg::*;

    typedef enum logic [2:0] {
        idle, addr_a, addr_b, load, wait_mm, addr_c, write_c, wait_b
    } state_t;

    state_t            state;
    state_t            state_n;
    logic              r_hs;
    logic              w_hs;
    logic              load_done;
    // index 0 collects A, index 1 collects B
    logic [1:0]        beat_hit;
    logic [1:0]        line_we;
    logic [4:0]        beat_cnt  [2];
    logic [BUF_AW-1:0] line_addr [2];
    line_t             pack      [2];
    logic [3:0]        c_idx;

    assign r_hs        = axi_rvalid_i && axi_rready_o;
    assign w_hs        = axi_wvalid_o && axi_wready_i;
    assign beat_hit[0] = r_hs && (axi_rid_i == ID_A);
    assign beat_hit[1] = r_hs && (axi_rid_i == ID_B);
    assign load_done   = (beat_cnt[0] == 5'd16) && (beat_cnt[1] == 5'd16) && (line_we == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            idle:    if (start_i)       state_n = addr_a;
            addr_a:  if (axi_arready_i) state_n = addr_b;
            addr_b:  if (axi_arready_i) state_n = load;
            load:    if (load_done)     state_n = wait_mm;
            wait_mm: if (mm_done_i)     state_n = addr_c;
            addr_c:  if (axi_awready_i) state_n = write_c;
            write_c: if (w_hs && axi_wlast_o) state_n = wait_b;
            wait_b:  if (axi_bvalid_i)  state_n = idle;
            default: state_n = idle;
        endcase
    end

    // read address, A then B back to back
    assign axi_arvalid_o = (state == addr_a) || (state == addr_b);
    assign axi_arid_o    = (state == addr_b) ? ID_B : ID_A;
    assign axi_araddr_o  = (state == addr_b) ? mat_b_addr_i : mat_a_addr_i;
    assign axi_arlen_o   = BURST_LEN;
    assign axi_arsize_o  = BURST_SIZE;
    assign axi_arburst_o = BURST_INCR;
    // A beats may already flow while B's address waits
    assign axi_rready_o  = (state == addr_b) || (state == load);

    // beat packing per read id
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (beat_hit[i]) begin
                pack[i][beat_cnt[i][1:0]] <= axi_rdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_we <= 2'b00;
            for (int i = 0; i < 2; i++) begin
                beat_cnt[i]  <= '0;
                line_addr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                line_we[i] <= beat_hit[i] && (beat_cnt[i][1:0] == 2'd3);
                if (state == idle) begin
                    beat_cnt[i]  <= '0;
                    line_addr[i] <= '0;
                end else if (beat_hit[i]) begin
                    beat_cnt[i] <= beat_cnt[i] + 5'd1;
                end
                if (line_we[i]) begin
                    line_addr[i] <= line_addr[i] + 1'b1;
                end
            end
        end
    end

    assign buf_a.we    = line_we[0];
    assign buf_a.waddr = line_addr[0];
    assign buf_a.wdata = pack[0];
    assign buf_b.we    = line_we[1];
    assign buf_b.waddr = line_addr[1];
    assign buf_b.wdata = pack[1];

    assign mm_start_o = (state == load) && load_done;

    // write C, row-major from the accumulator array
    assign axi_awvalid_o = (state == addr_c);
    assign axi_awaddr_o  = mat_c_addr_i;
    assign axi_awlen_o   = BURST_LEN;
    assign axi_awsize_o  = BURST_SIZE;
    assign axi_awburst_o = BURST_INCR;
    assign axi_wvalid_o  = (state == write_c);
    assign axi_wdata_o   = accum_i[c_idx[3:2]][c_idx[1:0]][DW-1:0];
    assign axi_wlast_o   = (c_idx == 4'd15);
    assign axi_bready_o  = (state == wait_b);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c_idx  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (state == wait_b) && axi_bvalid_i;
            if (state == idle) begin
                c_idx <= '0;
            end else if (w_hs) begin
                c_idx <= c_idx + 4'd1;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o));

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o));

endmodule

`default_nettype wire

// File: src/mm_csr.sv
// ==========================================================
// wishbone classic register block
// base addresses, start control and busy/done status
// ==========================================================
`default_nettype none

module mm_csr (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_we_i,
    input  wire  [7:0]  wb_adr_i,
    input  wire  [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        start_o,
    input  wire         done_i,
    output logic [31:0] mat_a_addr_o,
    output logic [31:0] mat_b_addr_o,
    output logic [31:0] mat_c_addr_o
);
    import mm_pkg::*;

    logic req;
    logic start_go;
    logic busy;
    logic done;

    // ack never twice in a row
    assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign start_go = req && wb_we_i && (wb_adr_i == REG_CTRL) && wb_dat_i[0] && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack_o     <= 1'b0;
            start_o      <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
            mat_a_addr_o <= '0;
            mat_b_addr_o <= '0;
            mat_c_addr_o <= '0;
        end else begin
            wb_ack_o <= req;
            start_o  <= start_go;
            if (start_go) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (done_i) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    REG_A_ADDR: mat_a_addr_o <= wb_dat_i;
                    REG_B_ADDR: mat_b_addr_o <= wb_dat_i;
                    REG_C_ADDR: mat_c_addr_o <= wb_dat_i;
                    default: ;
                endcase
            end
        end
    end

    // read data lands together with ack
    always_ff @(posedge clk) begin
        if (req && !wb_we_i) begin
            case (wb_adr_i)
                REG_STATUS: wb_dat_o <= {30'd0, done, busy};
                REG_A_ADDR: wb_dat_o <= mat_a_addr_o;
                REG_B_ADDR: wb_dat_o <= mat_b_addr_o;
                REG_C_ADDR: wb_dat_o <= mat_c_addr_o;
                default:    wb_dat_o <= '0;
            endcase
        end
    end

    // the DMA reports done only during a run
    done_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> busy);

endmodule

`default_nettype wire

// File: src/mm_engine.sv
// ==========================================================
// multiply engine
// outer-product accumulate of buffer lines into a 4x4 array
// ==========================================================
`default_nettype none

module mm_engine (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start_i,
    output logic                done_o,
    buf_if.reader               buf_a,
    buf_if.reader               buf_b,
    output mm_pkg::acc_array_t  accum_o
);
    import mm_pkg::*;

    logic              rd_active;
    logic              mac_en;
    logic [BUF_AW-1:0] k;

    // line k of A is column k, line k of B is row k
    assign buf_a.raddr = k;
    assign buf_b.raddr = k;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            mac_en    <= 1'b0;
            done_o    <= 1'b0;
            k         <= '0;
        end else begin
            // rdata follows raddr by one cycle
            mac_en <= rd_active;
            done_o <= mac_en && !rd_active;
            if (start_i) begin
                rd_active <= 1'b1;
                k         <= '0;
            end else if (rd_active) begin
                k <= k + 1'b1;
                if (k == BUF_AW'(SA_WIDTH - 1)) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || start_i) begin
            for (int i = 0; i < SA_WIDTH; i++) begin
                for (int j = 0; j < SA_WIDTH; j++) begin
                    accum_o[i][j] <= '0;
                end
            end
        end else if (mac_en) begin
            // acc[i][j] += A[i][k] * B[k][j]
            for (int i = 0; i < SA_WIDTH; i++) begin
                for (int j = 0; j < SA_WIDTH; j++) begin
                    accum_o[i][j] <= accum_o[i][j]
                                   + acc_t'(buf_a.rdata[i]) * acc_t'(buf_b.rdata[j]);
                end
            end
        end
    end

    no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !(rd_active || mac_en));

endmodule

`default_nettype wire

// File: src/mm_pkg.sv
// ==========================================================
// matrix-multiply accelerator package
// sizes, element and accumulator types, register offsets
// and AXI burst constants
// ==========================================================
`default_nettype none

package mm_pkg;

    // array and element sizes
    localparam int SA_WIDTH  = 4;
    localparam int DW        = 32;
    localparam int LINE_W    = SA_WIDTH * DW;
    localparam int BUF_DEPTH = SA_WIDTH;
    localparam int BUF_AW    = 2;
    localparam int ACC_W     = 2 * DW + 1;

    typedef logic signed [DW-1:0]    elem_t;
    // element 0 in the low bits, first beat of the line
    typedef elem_t [SA_WIDTH-1:0]    line_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef acc_t                    acc_array_t [SA_WIDTH][SA_WIDTH];

    // wishbone register offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_A_ADDR = 8'h08;
    localparam logic [7:0] REG_B_ADDR = 8'h0C;
    localparam logic [7:0] REG_C_ADDR = 8'h10;

    // axi bursts are always 16 beats of one word
    localparam logic [7:0] BURST_LEN  = 8'd15;
    localparam logic [2:0] BURST_SIZE = 3'd2;
    localparam logic [1:0] BURST_INCR = 2'd1;
    localparam logic [3:0] ID_A       = 4'd0;
    localparam logic [3:0] ID_B       = 4'd1;

endpackage

`default_nettype wire

// File: src/mm_top.sv
// ==========================================================
// matrix-multiply accelerator top level
// registers, DMA, two operand buffers and the multiply engine
// ==========================================================
`default_nettype none

module mm_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_we_i,
    input  wire  [7:0]  wb_adr_i,
    input  wire  [31:0] wb_dat_i,
    output wire  [31:0] wb_dat_o,
    output wire         wb_ack_o,
    output wire  [3:0]  axi_arid_o,
    output wire  [31:0] axi_araddr_o,
    output wire  [7:0]  axi_arlen_o,
    output wire  [2:0]  axi_arsize_o,
    output wire  [1:0]  axi_arburst_o,
    output wire         axi_arvalid_o,
    input  wire         axi_arready_i,
    input  wire  [3:0]  axi_rid_i,
    input  wire  [31:0] axi_rdata_i,
    input  wire         axi_rvalid_i,
    output wire         axi_rready_o,
    output wire  [31:0] axi_awaddr_o,
    output wire  [7:0]  axi_awlen_o,
    output wire  [2:0]  axi_awsize_o,
    output wire  [1:0]  axi_awburst_o,
    output wire         axi_awvalid_o,
    input  wire         axi_awready_i,
    output wire  [31:0] axi_wdata_o,
    output wire         axi_wlast_o,
    output wire         axi_wvalid_o,
    input  wire         axi_wready_i,
    input  wire         axi_bvalid_i,
    output wire         axi_bready_o
);
    import mm_pkg::*;

    wire        start;
    wire        done;
    wire [31:0] mat_a_addr;
    wire [31:0] mat_b_addr;
    wire [31:0] mat_c_addr;
    wire        mm_start;
    wire        mm_done;
    acc_array_t accum;

    buf_if buf_a ();
    buf_if buf_b ();

    mm_csr u_csr (
        .clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o,
        .start_o      (start),
        .done_i       (done),
        .mat_a_addr_o (mat_a_addr),
        .mat_b_addr_o (mat_b_addr),
        .mat_c_addr_o (mat_c_addr)
    );

    dma_engine u_dma (
        .clk, .rst_n,
        .start_i      (start),
        .done_o       (done),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .axi_arid_o, .axi_araddr_o, .axi_arlen_o, .axi_arsize_o, .axi_arburst_o,
        .axi_arvalid_o, .axi_arready_i,
        .axi_rid_i, .axi_rdata_i, .axi_rvalid_i, .axi_rready_o,
        .axi_awaddr_o, .axi_awlen_o, .axi_awsize_o, .axi_awburst_o,
        .axi_awvalid_o, .axi_awready_i,
        .axi_wdata_o, .axi_wlast_o, .axi_wvalid_o, .axi_wready_i,
        .axi_bvalid_i, .axi_bready_o,
        .buf_a        (buf_a.writer),
        .buf_b        (buf_b.writer),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    operand_buffer u_buf_a (.clk, .bus (buf_a.mem));
    operand_buffer u_buf_b (.clk, .bus (buf_b.mem));

    mm_engine u_mm (
        .clk, .rst_n,
        .start_i (mm_start),
        .done_o  (mm_done),
        .buf_a   (buf_a.reader),
        .buf_b   (buf_b.reader),
        .accum_o (accum)
    );

endmodule

`default_nettype wire

// File: src/operand_buffer.sv
// ==========================================================
// operand buffer
// four 128-bit lines, one write port, registered read
// ==========================================================
`default_nettype none

module operand_buffer (
    input  wire clk,
    buf_if.mem  bus
);
    import mm_pkg::*;

    logic [LINE_W-1:0] mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.waddr] <= bus.wdata;
        end
        bus.rdata <= mem[bus.raddr];
    end

endmodule

`default_nettype wire

// File: test/tb_axi_mem.sv
// ==========================================================
// AXI memory model for the accelerator testbench
// word-addressed RAM with random ready, valid and B delays
// ==========================================================
`default_nettype none

module tb_axi_mem (
    input  wire         clk,
    input  wire         heavy_i,
    input  wire  [3:0]  arid_i,
    input  wire  [31:0] araddr_i,
    input  wire  [7:0]  arlen_i,
    input  wire  [2:0]  arsize_i,
    input  wire  [1:0]  arburst_i,
    input  wire         arvalid_i,
    output logic        arready_o,
    output logic [3:0]  rid_o,
    output logic [31:0] rdata_o,
    output logic        rvalid_o,
    input  wire         rready_i,
    input  wire  [31:0] awaddr_i,
    input  wire  [7:0]  awlen_i,
    input  wire  [2:0]  awsize_i,
    input  wire  [1:0]  awburst_i,
    input  wire         awvalid_i,
    output logic        awready_o,
    input  wire  [31:0] wdata_i,
    input  wire         wlast_i,
    input  wire         wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  wire         bready_i
);
    logic [31:0] mem [1024];
    logic [9:0]  rd_ptr [2];
    int          rd_left [2];
    logic        last_id;
    logic        r_sent;
    logic [9:0]  wr_ptr;
    int          wr_beats;
    logic        b_pend;
    logic        b_sent;
    int          b_wait;
    int          aw_bursts;
    int          proto_errs;

    // mostly ready when light, mostly stalled when heavy
    function automatic logic draw_ready();
        if (heavy_i) begin
            return $urandom_range(3, 0) == 0;
        end
        return $urandom_range(3, 0) != 0;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {20'hfeed0, i[9:0], 2'b00};
        end
        {arready_o, rvalid_o, awready_o, wready_o, bvalid_o} = '0;
        rid_o = '0;
        rdata_o = '0;
        rd_left = '{0, 0};
        rd_ptr = '{10'd0, 10'd0};
        {last_id, r_sent, b_pend, b_sent} = '0;
        wr_ptr = '0;
        wr_beats = 0;
        b_wait = 0;
        aw_bursts = 0;
        proto_errs = 0;
    end

    // all channel decisions at the falling edge, transfers land on the next rise
    always @(negedge clk) begin
        // B after the last W beat, never in the same cycle
        if (b_sent) begin
            bvalid_o = 1'b0;
            b_sent = 1'b0;
        end
        if (b_pend && !bvalid_o) begin
            if (b_wait == 0) bvalid_o = 1'b1;
            else b_wait = b_wait - 1;
        end
        if (bvalid_o && bready_i) begin
            b_sent = 1'b1;
            b_pend = 1'b0;
        end

        wready_o = draw_ready();
        if (wvalid_i && wready_o) begin
            mem[wr_ptr] = wdata_i;
            wr_ptr = wr_ptr + 10'd1;
            wr_beats = wr_beats + 1;
            if (wlast_i != (wr_beats == 16)) proto_errs = proto_errs + 1;
            if (wlast_i) begin
                b_pend = 1'b1;
                b_wait = heavy_i ? $urandom_range(8, 0) : $urandom_range(1, 0);
            end
        end

        awready_o = draw_ready();
        if (awvalid_i && awready_o) begin
            if (awlen_i != 8'd15 || awsize_i != 3'd2 || awburst_i != 2'd1) begin
                proto_errs = proto_errs + 1;
            end
            wr_ptr = awaddr_i[11:2];
            wr_beats = 0;
            aw_bursts = aw_bursts + 1;
        end

        // R ahead of AR so a burst starts one cycle after its address
        if (r_sent) begin
            rvalid_o = 1'b0;
            r_sent = 1'b0;
        end
        if (!rvalid_o && (rd_left[0] > 0 || rd_left[1] > 0) && draw_ready()) begin
            if (rd_left[0] > 0 && rd_left[1] > 0) last_id = !last_id;
            else last_id = (rd_left[1] > 0);
            rid_o = {3'd0, last_id};
            rdata_o = mem[rd_ptr[last_id]];
            rvalid_o = 1'b1;
        end
        if (rvalid_o && rready_i) begin
            rd_ptr[rid_o[0]] = rd_ptr[rid_o[0]] + 10'd1;
            rd_left[rid_o[0]] = rd_left[rid_o[0]] - 1;
            r_sent = 1'b1;
        end

        arready_o = draw_ready();
        if (arvalid_i && arready_o) begin
            if (arlen_i != 8'd15 || arsize_i != 3'd2 || arburst_i != 2'd1 || arid_i > 4'd1) begin
                proto_errs = proto_errs + 1;
            end else begin
                rd_ptr[arid_i[0]] = araddr_i[11:2];
                rd_left[arid_i[0]] = 16;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_mm_top.sv
// ==========================================================
// matrix-multiply accelerator testbench
// table-driven runs over wishbone with a random AXI memory
// ==========================================================
`default_nettype none

module tb_mm_top;
    import mm_pkg::*;

    typedef struct packed {
        logic [31:0] a_base;
        logic [31:0] b_base;
        logic [31:0] c_base;
        logic [5:0]  elem_bits;
        logic        restart;
        logic        heavy;
    } row_t;

    localparam int NROWS = 4;

    // port names match the DUT
    logic        clk;
    logic        rst_n;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [7:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    wire  [31:0] wb_dat_o;
    wire         wb_ack_o;
    wire  [3:0]  axi_arid_o;
    wire  [31:0] axi_araddr_o;
    wire  [7:0]  axi_arlen_o;
    wire  [2:0]  axi_arsize_o;
    wire  [1:0]  axi_arburst_o;
    wire         axi_arvalid_o;
    wire         axi_arready_i;
    wire  [3:0]  axi_rid_i;
    wire  [31:0] axi_rdata_i;
    wire         axi_rvalid_i;
    wire         axi_rready_o;
    wire  [31:0] axi_awaddr_o;
    wire  [7:0]  axi_awlen_o;
    wire  [2:0]  axi_awsize_o;
    wire  [1:0]  axi_awburst_o;
    wire         axi_awvalid_o;
    wire         axi_awready_i;
    wire  [31:0] axi_wdata_o;
    wire         axi_wlast_o;
    wire         axi_wvalid_o;
    wire         axi_wready_i;
    wire         axi_bvalid_i;
    wire         axi_bready_o;
    logic        heavy;

    row_t        rows [NROWS];
    logic [31:0] exp_c [NROWS][16];
    int          errors = 0;
    int          checks = 0;
    int          ran = 0;
    int          passed = 0;
    bit          timed_out = 1'b0;

    mm_top dut (.*);

    tb_axi_mem u_mem (
        .clk       (clk),           .heavy_i   (heavy),
        .arid_i    (axi_arid_o),    .araddr_i  (axi_araddr_o),
        .arlen_i   (axi_arlen_o),   .arsize_i  (axi_arsize_o),
        .arburst_i (axi_arburst_o), .arvalid_i (axi_arvalid_o),
        .arready_o (axi_arready_i), .rid_o     (axi_rid_i),
        .rdata_o   (axi_rdata_i),   .rvalid_o  (axi_rvalid_i),
        .rready_i  (axi_rready_o),  .awaddr_i  (axi_awaddr_o),
        .awlen_i   (axi_awlen_o),   .awsize_i  (axi_awsize_o),
        .awburst_i (axi_awburst_o), .awvalid_i (axi_awvalid_o),
        .awready_o (axi_awready_i), .wdata_i   (axi_wdata_o),
        .wlast_i   (axi_wlast_o),   .wvalid_i  (axi_wvalid_o),
        .wready_o  (axi_wready_i),  .bvalid_o  (axi_bvalid_i),
        .bready_i  (axi_bready_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one classic cycle, called and returning on a falling edge
    task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int n;
        n = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        @(negedge clk);
        while (!wb_ack_o && n < 20) begin
            @(negedge clk);
            n++;
        end
        rdat = wb_dat_o;
        if (!wb_ack_o) begin
            $display("timed out waiting for a wishbone ack at time %0t", $time);
            errors++;
            timed_out = 1'b1;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, 32'h0, dat);
    endtask

    task automatic run_test(input int r);
        logic signed [31:0] a [4][4];
        logic signed [31:0] b [4][4];
        logic [31:0]        rd;
        longint             acc;
        int                 err0;
        int                 aw0;
        int                 polls;
        int                 a_w;
        int                 b_w;
        int                 c_w;

        err0 = errors;
        heavy = rows[r].heavy;
        a_w = rows[r].a_base >> 2;
        b_w = rows[r].b_base >> 2;
        c_w = rows[r].c_base >> 2;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                a[i][j] = $signed($urandom) >>> (32 - rows[r].elem_bits);
                b[i][j] = $signed($urandom) >>> (32 - rows[r].elem_bits);
            end
        end
        // A column-major, B row-major
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                u_mem.mem[a_w + k * 4 + i] = a[i][k];
                u_mem.mem[b_w + k * 4 + i] = b[k][i];
            end
        end
        // exact product, low word kept
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                acc = 0;
                for (int k = 0; k < 4; k++) begin
                    acc += longint'(a[i][k]) * longint'(b[k][j]);
                end
                exp_c[r][i * 4 + j] = acc[31:0];
            end
        end

        wb_write(REG_A_ADDR, rows[r].a_base);
        wb_write(REG_B_ADDR, rows[r].b_base);
        wb_write(REG_C_ADDR, rows[r].c_base);
        wb_read(REG_A_ADDR, rd);
        check("A base readback", rd, rows[r].a_base);
        wb_read(REG_B_ADDR, rd);
        check("B base readback", rd, rows[r].b_base);
        wb_read(REG_C_ADDR, rd);
        check("C base readback", rd, rows[r].c_base);
        wb_read(8'h14, rd);
        check("unmapped offset", rd, 32'h0);

        aw0 = u_mem.aw_bursts;
        wb_write(REG_CTRL, 32'h1);
        wb_read(REG_STATUS, rd);
        check("status after start", rd, 32'h1);
        if (rows[r].restart) begin
            wb_write(REG_CTRL, 32'h1);
        end

        rd = 32'h1;
        polls = 0;
        while (rd[0] && polls < 500) begin
            wb_read(REG_STATUS, rd);
            polls++;
        end
        if (rd[0]) begin
            $display("timed out waiting for the accelerator to finish in test %0d", r);
            errors++;
            timed_out = 1'b1;
        end else begin
            check("status after completion", rd, 32'h2);
            // an idle stretch shows any start that was wrongly queued
            repeat (20) @(negedge clk);
            wb_read(REG_STATUS, rd);
            check("status while idle", rd, 32'h2);
            check("C write bursts", u_mem.aw_bursts - aw0, 32'd1);
            check("AXI protocol errors", u_mem.proto_errs, 32'd0);
            for (int w = 0; w < 16; w++) begin
                check($sformatf("C[%0d][%0d]", w / 4, w % 4), u_mem.mem[c_w + w], exp_c[r][w]);
            end
            for (int p = 0; p < r; p++) begin
                for (int w = 0; w < 16; w++) begin
                    check($sformatf("earlier C of test %0d word %0d", p, w),
                          u_mem.mem[(rows[p].c_base >> 2) + w], exp_c[p][w]);
                end
            end
        end

        ran++;
        if (errors == err0) begin
            passed++;
            $display("test %0d passed", r);
        end else begin
            $display("test %0d failed with %0d errors", r, errors - err0);
        end
    endtask

    initial begin
        void'($urandom(32'hd608));
        rst_n    = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = 8'h0;
        wb_dat_i = 32'h0;
        heavy    = 1'b0;
        // A base, B base, C base, element bits, restart while busy, heavy stalls
        rows[0] = '{32'h000, 32'h100, 32'h200, 6'd8,  1'b0, 1'b0};
        rows[1] = '{32'h300, 32'h340, 32'h380, 6'd32, 1'b0, 1'b0};
        rows[2] = '{32'h400, 32'h500, 32'h600, 6'd32, 1'b1, 1'b0};
        rows[3] = '{32'h700, 32'h740, 32'h780, 6'd20, 1'b0, 1'b1};
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int r = 0; r < NROWS && !timed_out; r++) begin
            run_test(r);
        end
        $display("%0d of %0d tests passed, %0d checks, %0d errors", passed, ran, checks, errors);
        if (errors == 0 && ran == NROWS) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
